/* logic/mem_stream_pkg.sv */
// Stream-side definitions shared by the bridge and the bench.
// Header layout, MSB first: msg type, size, byte address, tag.
// Sizes use log2 bytes so they map straight onto AXI size.
package mem_stream_pkg;

  typedef enum logic [1:0] {
    e_msg_rd    = 2'b00,
    e_msg_wr    = 2'b01,
    e_msg_uc_rd = 2'b10,
    e_msg_uc_wr = 2'b11
  } msg_type_e;

  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } msg_size_e;

  localparam int addr_width = 11;  // byte address, 2 KiB space
  localparam int tag_width  = 4;
  localparam int data_width = 64;

  // header field positions
  localparam int addr_lsb     = tag_width;
  localparam int size_lsb     = addr_lsb + addr_width;
  localparam int type_lsb     = size_lsb + $bits(msg_size_e);
  localparam int header_width = type_lsb + $bits(msg_type_e);  // 19 bits

  localparam int mem_words = 256;  // 64-bit words behind the bridge

endpackage

/* logic/axi_bus_pkg.sv */
// AXI4 field encodings used by the manager and the memory.
// Only single-beat transfers are used, so no len or id here.
package axi_bus_pkg;

  typedef enum logic [1:0] {
    e_burst_fixed = 2'b00,
    e_burst_incr  = 2'b01,
    e_burst_wrap  = 2'b10
  } burst_e;

  // response codes, the memory only ever answers okay
  typedef enum logic [1:0] {
    e_resp_okay   = 2'b00,
    e_resp_exokay = 2'b01,
    e_resp_slverr = 2'b10,
    e_resp_decerr = 2'b11
  } resp_e;

  localparam int strb_width = 8;  // byte lanes of the 64-bit data bus
  localparam int size_width = 3;

endpackage

/* logic/one_entry_buffer.sv */
// One-deep valid/ready register slice.
// Accepts only when empty, so throughput is one item every two cycles.
// yumi_i must only be raised while v_o is high.
module one_entry_buffer #(
  parameter int width = 8
) (
  input  logic             clk_i,
  input  logic             reset_i,

  input  logic             v_i,
  output logic             ready_o,
  input  logic [width-1:0] data_i,

  output logic             v_o,
  input  logic             yumi_i,
  output logic [width-1:0] data_o
);

  logic             full_r;
  logic [width-1:0] data_r;

  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (v_i & ready_o) begin
      full_r <= 1'b1;
    end else if (yumi_i) begin
      full_r <= 1'b0;  // free again next cycle
    end
  end

  // payload register
  always_ff @(posedge clk_i) begin
    if (v_i & ready_o) begin
      data_r <= data_i;
    end
  end

  // consumer may not pop an empty slice
  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

/* logic/axi_manager.sv */
// Bridges buffered stream requests to single-beat AXI4 transactions.
// Only one AXI transaction is open at a time, which keeps responses in order.
// Sub-word write data must already sit in the byte lanes of its address.
// bresp and rresp are not checked.
module axi_manager (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic [mem_stream_pkg::header_width-1:0] req_header_i,
  input  logic [mem_stream_pkg::data_width-1:0]   req_data_i,
  input  logic                                    req_v_i,
  output logic                                    req_yumi_o,

  output logic [mem_stream_pkg::header_width-1:0] resp_header_o,
  output logic [mem_stream_pkg::data_width-1:0]   resp_data_o,
  output logic                                    resp_v_o,
  input  logic                                    resp_ready_i,

  output logic [mem_stream_pkg::addr_width-1:0]   awaddr_o,
  output logic [axi_bus_pkg::size_width-1:0]      awsize_o,
  output axi_bus_pkg::burst_e                     awburst_o,
  output logic                                    awvalid_o,
  input  logic                                    awready_i,

  output logic [mem_stream_pkg::data_width-1:0]   wdata_o,
  output logic [axi_bus_pkg::strb_width-1:0]      wstrb_o,
  output logic                                    wlast_o,
  output logic                                    wvalid_o,
  input  logic                                    wready_i,

  input  axi_bus_pkg::resp_e                      bresp_i,
  input  logic                                    bvalid_i,
  output logic                                    bready_o,

  output logic [mem_stream_pkg::addr_width-1:0]   araddr_o,
  output logic [axi_bus_pkg::size_width-1:0]      arsize_o,
  output axi_bus_pkg::burst_e                     arburst_o,
  output logic                                    arvalid_o,
  input  logic                                    arready_i,

  input  logic [mem_stream_pkg::data_width-1:0]   rdata_i,
  input  axi_bus_pkg::resp_e                      rresp_i,
  input  logic                                    rlast_i,
  input  logic                                    rvalid_i,
  output logic                                    rready_o
);

  typedef enum logic [2:0] {
    e_ready,
    e_write,
    e_wresp,
    e_read,
    e_rdata
  } state_e;

  state_e state_r, state_n;

  mem_stream_pkg::msg_type_e                req_type;
  mem_stream_pkg::msg_size_e                req_size;
  logic [mem_stream_pkg::addr_width-1:0]    req_addr;
  logic                                     req_is_write;
  logic                                     aw_sent_r, w_sent_r;
  logic                                     aw_hs, w_hs;

  assign req_type = mem_stream_pkg::msg_type_e'(req_header_i[mem_stream_pkg::type_lsb +: 2]);
  assign req_size = mem_stream_pkg::msg_size_e'(req_header_i[mem_stream_pkg::size_lsb +: 2]);
  assign req_addr = req_header_i[mem_stream_pkg::addr_lsb +: mem_stream_pkg::addr_width];
  assign req_is_write = (req_type == mem_stream_pkg::e_msg_wr)
                      | (req_type == mem_stream_pkg::e_msg_uc_wr);

  assign awaddr_o  = req_addr;
  assign awsize_o  = axi_bus_pkg::size_width'(req_size);
  assign awburst_o = axi_bus_pkg::e_burst_incr;
  assign araddr_o  = req_addr;
  assign arsize_o  = axi_bus_pkg::size_width'(req_size);
  assign arburst_o = axi_bus_pkg::e_burst_incr;
  assign wdata_o   = req_data_i;
  assign wlast_o   = 1'b1;

  // lanes from size, shifted up to the address offset
  always_comb begin
    case (req_size)
      mem_stream_pkg::e_size_1: wstrb_o = 8'h01 << req_addr[2:0];
      mem_stream_pkg::e_size_2: wstrb_o = 8'h03 << req_addr[2:0];
      mem_stream_pkg::e_size_4: wstrb_o = 8'h0f << req_addr[2:0];
      default:                  wstrb_o = 8'hff;
    endcase
  end

  assign aw_hs = awvalid_o & awready_i;
  assign w_hs  = wvalid_o & wready_i;

  // header is echoed, writes return zero data
  assign resp_header_o = req_header_i;
  assign resp_data_o   = (state_r == e_rdata) ? rdata_i : '0;
  assign req_yumi_o    = resp_v_o & resp_ready_i;

  always_comb begin
    state_n   = state_r;
    awvalid_o = 1'b0;
    wvalid_o  = 1'b0;
    bready_o  = 1'b0;
    arvalid_o = 1'b0;
    rready_o  = 1'b0;
    resp_v_o  = 1'b0;
    case (state_r)
      e_ready: begin
        if (req_v_i) begin
          state_n = req_is_write ? e_write : e_read;
        end
      end
      e_write: begin
        awvalid_o = ~aw_sent_r;
        wvalid_o  = ~w_sent_r;
        if ((aw_sent_r | aw_hs) & (w_sent_r | w_hs)) begin
          state_n = e_wresp;
        end
      end
      e_wresp: begin
        bready_o = resp_ready_i;  // stall b while the response slot is full
        resp_v_o = bvalid_i;
        if (bvalid_i & resp_ready_i) begin
          state_n = e_ready;
        end
      end
      e_read: begin
        arvalid_o = 1'b1;
        if (arready_i) begin
          state_n = e_rdata;
        end
      end
      e_rdata: begin
        rready_o = resp_ready_i;
        resp_v_o = rvalid_i;
        if (rvalid_i & resp_ready_i) begin
          state_n = e_ready;
        end
      end
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= e_ready;
      aw_sent_r <= 1'b0;
      w_sent_r  <= 1'b0;
    end else begin
      state_r <= state_n;
      if (state_r == e_ready) begin
        aw_sent_r <= 1'b0;
        w_sent_r  <= 1'b0;
      end else begin
        if (aw_hs) aw_sent_r <= 1'b1;
        if (w_hs) w_sent_r <= 1'b1;
      end
    end
  end

  aw_held_until_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o));

  // misaligned requests are not supported
  req_addr_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i |-> (req_addr[2:0] & ((3'b001 << req_size) - 3'b001)) == 3'b000);

  // memory may only answer while a write response is awaited
  b_only_in_wresp: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i |-> state_r == e_wresp);

endmodule

/* logic/axi_mem_subordinate.sv */
// Single-beat AXI4 memory, 256 x 64 bits, no reset on the array.
// awready is held off for one cycle of awvalid, so aw and w never complete together.
// Size and burst are ignored, the write strobes carry the access width.
// One write and one read may be open, and no ordering between them is kept.
module axi_mem_subordinate (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic [mem_stream_pkg::addr_width-1:0] awaddr_i,
  input  logic [axi_bus_pkg::size_width-1:0]    awsize_i,
  input  axi_bus_pkg::burst_e                   awburst_i,
  input  logic                                  awvalid_i,
  output logic                                  awready_o,

  input  logic [mem_stream_pkg::data_width-1:0] wdata_i,
  input  logic [axi_bus_pkg::strb_width-1:0]    wstrb_i,
  input  logic                                  wlast_i,
  input  logic                                  wvalid_i,
  output logic                                  wready_o,

  output axi_bus_pkg::resp_e                    bresp_o,
  output logic                                  bvalid_o,
  input  logic                                  bready_i,

  input  logic [mem_stream_pkg::addr_width-1:0] araddr_i,
  input  logic [axi_bus_pkg::size_width-1:0]    arsize_i,
  input  axi_bus_pkg::burst_e                   arburst_i,
  input  logic                                  arvalid_i,
  output logic                                  arready_o,

  output logic [mem_stream_pkg::data_width-1:0] rdata_o,
  output axi_bus_pkg::resp_e                    rresp_o,
  output logic                                  rlast_o,
  output logic                                  rvalid_o,
  input  logic                                  rready_i
);

  logic [mem_stream_pkg::data_width-1:0] mem_r [mem_stream_pkg::mem_words];

  logic [$clog2(mem_stream_pkg::mem_words)-1:0] waddr_r;
  logic [mem_stream_pkg::data_width-1:0]        wdata_r;
  logic [axi_bus_pkg::strb_width-1:0]           wstrb_r;
  logic [mem_stream_pkg::data_width-1:0]        rdata_r;
  logic aw_got_r, w_got_r, aw_wait_r;
  logic bvalid_r, rvalid_r;
  logic aw_hs, w_hs, ar_hs, write_go;

  assign awready_o = aw_wait_r & ~aw_got_r & ~bvalid_r;  // second cycle of awvalid
  assign wready_o  = ~w_got_r & ~bvalid_r;
  assign arready_o = ~rvalid_r;

  assign aw_hs    = awvalid_i & awready_o;
  assign w_hs     = wvalid_i & wready_o;
  assign ar_hs    = arvalid_i & arready_o;
  assign write_go = aw_got_r & w_got_r;

  assign bvalid_o = bvalid_r;
  assign bresp_o  = axi_bus_pkg::e_resp_okay;
  assign rvalid_o = rvalid_r;
  assign rdata_o  = rdata_r;
  assign rresp_o  = axi_bus_pkg::e_resp_okay;
  assign rlast_o  = 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_wait_r <= 1'b0;
      aw_got_r  <= 1'b0;
      w_got_r   <= 1'b0;
      bvalid_r  <= 1'b0;
      rvalid_r  <= 1'b0;
    end else begin
      aw_wait_r <= awvalid_i & ~aw_hs;
      if (write_go) begin
        aw_got_r <= 1'b0;
        w_got_r  <= 1'b0;
        bvalid_r <= 1'b1;  // response after the array update
      end else begin
        if (aw_hs) aw_got_r <= 1'b1;
        if (w_hs) w_got_r <= 1'b1;
        if (bready_i) bvalid_r <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_r <= 1'b1;
      end else if (rready_i) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  // captured address and data, no reset needed
  always_ff @(posedge clk_i) begin
    if (aw_hs) waddr_r <= awaddr_i[mem_stream_pkg::addr_width-1:3];
    if (w_hs) begin
      wdata_r <= wdata_i;
      wstrb_r <= wstrb_i;
    end
    if (ar_hs) rdata_r <= mem_r[araddr_i[mem_stream_pkg::addr_width-1:3]];
  end

  always_ff @(posedge clk_i) begin
    if (write_go) begin
      for (int i = 0; i < axi_bus_pkg::strb_width; i++) begin
        if (wstrb_r[i]) mem_r[waddr_r][8*i +: 8] <= wdata_r[8*i +: 8];
      end
    end
  end

  // every write is a single beat
  w_single_beat: assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_i && wready_o |-> wlast_i);

endmodule

/* logic/mem_axi_top.sv */
// Stream-to-AXI bridge with a 2 KiB AXI memory behind it.
// At most two requests in flight: one served, one waiting in the input slice.
module mem_axi_top (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic [mem_stream_pkg::header_width-1:0] fwd_header_i,
  input  logic [mem_stream_pkg::data_width-1:0]   fwd_data_i,
  input  logic                                    fwd_v_i,
  output logic                                    fwd_ready_o,

  output logic [mem_stream_pkg::header_width-1:0] rev_header_o,
  output logic [mem_stream_pkg::data_width-1:0]   rev_data_o,
  output logic                                    rev_v_o,
  input  logic                                    rev_ready_i
);

  logic [mem_stream_pkg::header_width-1:0] req_header, resp_header;
  logic [mem_stream_pkg::data_width-1:0]   req_data, resp_data;
  logic req_v, req_yumi, resp_v, resp_ready;

  // AXI channels between bridge and memory
  logic [mem_stream_pkg::addr_width-1:0] awaddr, araddr;
  logic [axi_bus_pkg::size_width-1:0]    awsize, arsize;
  axi_bus_pkg::burst_e                   awburst, arburst;
  logic [mem_stream_pkg::data_width-1:0] wdata, rdata;
  logic [axi_bus_pkg::strb_width-1:0]    wstrb;
  axi_bus_pkg::resp_e                    bresp, rresp;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rlast, rvalid, rready;

  one_entry_buffer #(
    .width(mem_stream_pkg::header_width + mem_stream_pkg::data_width)
  ) req_buf_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(fwd_v_i), .ready_o(fwd_ready_o), .data_i({fwd_data_i, fwd_header_i}),
    .v_o(req_v), .yumi_i(req_yumi), .data_o({req_data, req_header})
  );

  axi_manager manager_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_header_i(req_header), .req_data_i(req_data), .req_v_i(req_v), .req_yumi_o(req_yumi),
    .resp_header_o(resp_header), .resp_data_o(resp_data),
    .resp_v_o(resp_v), .resp_ready_i(resp_ready),
    .awaddr_o(awaddr), .awsize_o(awsize), .awburst_o(awburst),
    .awvalid_o(awvalid), .awready_i(awready),
    .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .wvalid_o(wvalid), .wready_i(wready),
    .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready),
    .araddr_o(araddr), .arsize_o(arsize), .arburst_o(arburst),
    .arvalid_o(arvalid), .arready_i(arready),
    .rdata_i(rdata), .rresp_i(rresp), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready)
  );

  one_entry_buffer #(
    .width(mem_stream_pkg::header_width + mem_stream_pkg::data_width)
  ) resp_buf_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(resp_v), .ready_o(resp_ready), .data_i({resp_data, resp_header}),
    .v_o(rev_v_o), .yumi_i(rev_v_o & rev_ready_i), .data_o({rev_data_o, rev_header_o})
  );

  axi_mem_subordinate mem_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .awaddr_i(awaddr), .awsize_i(awsize), .awburst_i(awburst),
    .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast), .wvalid_i(wvalid), .wready_o(wready),
    .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
    .araddr_i(araddr), .arsize_i(arsize), .arburst_i(arburst),
    .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rresp_o(rresp), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready)
  );

endmodule

/* bench/clock_gen.sv */
// Free-running clock with a period of 4 time units.
// Reset is high from time zero through the first 4 rising edges.
module clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;

  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    reset_o <= 1'b0;  // released on the 4th edge
  end

endmodule

/* bench/mem_axi_tb.sv */
// Directed tests for the stream-to-AXI bridge and its memory.
// Inputs change on the falling edge, outputs are sampled there too.
// Reads are always 8 bytes and only touch words the bench has written.
module mem_axi_tb;

  localparam int hw = mem_stream_pkg::header_width;
  localparam int dw = mem_stream_pkg::data_width;
  localparam int timeout_cycles = 4000;  // ~80 requests, each well under 50 cycles

  logic          clk, reset;
  logic [hw-1:0] fwd_header, rev_header;
  logic [dw-1:0] fwd_data, rev_data;
  logic          fwd_v, fwd_ready, rev_v, rev_ready;

  logic [7:0] ref_mem [mem_stream_pkg::mem_words*8];  // byte-wide reference
  logic [mem_stream_pkg::tag_width-1:0] next_tag;
  int  checks, mismatches, cycles;
  bit  gaps;  // random rev_ready stalls

  clock_gen clk_gen_i (.clk_o(clk), .reset_o(reset));

  mem_axi_top dut_i (
    .clk_i(clk), .reset_i(reset),
    .fwd_header_i(fwd_header), .fwd_data_i(fwd_data), .fwd_v_i(fwd_v), .fwd_ready_o(fwd_ready),
    .rev_header_o(rev_header), .rev_data_o(rev_data), .rev_v_o(rev_v), .rev_ready_i(rev_ready)
  );

  task automatic check(input string name, input logic [dw-1:0] expected,
                       input logic [dw-1:0] actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [hw-1:0] make_header(input mem_stream_pkg::msg_type_e t,
      input mem_stream_pkg::msg_size_e s, input logic [10:0] addr, input logic [3:0] tag);
    return {t, s, addr, tag};
  endfunction

  function automatic bit is_write(input mem_stream_pkg::msg_type_e t);
    return (t == mem_stream_pkg::e_msg_wr) || (t == mem_stream_pkg::e_msg_uc_wr);
  endfunction

  // whole 64-bit word holding addr
  function automatic logic [dw-1:0] ref_word(input logic [10:0] addr);
    logic [dw-1:0] w;
    w = '0;
    for (int b = 0; b < 8; b++) begin
      w = {ref_mem[11'({addr[10:3], 3'b000} + b)], w[dw-1:8]};
    end
    return w;
  endfunction

  // data sits in the lanes of its address
  task automatic ref_write(input mem_stream_pkg::msg_size_e s, input logic [10:0] addr,
                           input logic [dw-1:0] data);
    logic [dw-1:0] lanes;
    for (int b = 0; b < (1 << s); b++) begin
      lanes = data >> (8 * (int'(addr[2:0]) + b));
      ref_mem[11'(addr + b)] = lanes[7:0];
    end
  endtask

  task automatic push(input logic [hw-1:0] hdr, input logic [dw-1:0] data);
    @(negedge clk);
    fwd_header = hdr;
    fwd_data   = data;
    fwd_v      = 1'b1;
    while (fwd_ready !== 1'b1) @(negedge clk);
    @(negedge clk);  // taken on the edge before this
    fwd_v = 1'b0;
  endtask

  task automatic pull(output logic [hw-1:0] hdr, output logic [dw-1:0] data);
    do begin
      @(negedge clk);
      rev_ready = gaps ? ($urandom_range(0, 2) != 0) : 1'b1;
    end while (!(rev_v === 1'b1 && rev_ready));
    hdr  = rev_header;
    data = rev_data;
  endtask

  // one request, one response, header echo and data checked
  task automatic access(input string name, input mem_stream_pkg::msg_type_e t,
      input mem_stream_pkg::msg_size_e s, input logic [10:0] addr, input logic [dw-1:0] data);
    logic [hw-1:0] hdr, got_hdr;
    logic [dw-1:0] got_data, expected;
    hdr = make_header(t, s, addr, next_tag);
    next_tag++;
    push(hdr, data);
    pull(got_hdr, got_data);
    check({name, " header"}, dw'(hdr), dw'(got_hdr));
    if (is_write(t)) begin
      ref_write(s, addr, data);
      expected = '0;
    end else begin
      expected = ref_word(addr);
    end
    check({name, " data"}, expected, got_data);
  endtask

  task automatic write_then_read_test;
    access("write_then_read wr", mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_8,
           11'h040, {$urandom, $urandom});
    access("write_then_read rd", mem_stream_pkg::e_msg_rd, mem_stream_pkg::e_size_8,
           11'h040, '0);
  endtask

  task automatic strobe_test;
    logic [10:0] base;
    base = 11'h100;
    access("strobe init", mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_8, base,
           {$urandom, $urandom});
    for (int off = 0; off < 8; off++) begin
      access("strobe byte wr", mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_1,
             11'(base + off), {$urandom, $urandom});
    end
    access("strobe byte rd", mem_stream_pkg::e_msg_rd, mem_stream_pkg::e_size_8, base, '0);
    for (int off = 0; off < 8; off += 2) begin
      access("strobe half wr", mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_2,
             11'(base + off), {$urandom, $urandom});
    end
    access("strobe half rd", mem_stream_pkg::e_msg_rd, mem_stream_pkg::e_size_8, base, '0);
    for (int off = 0; off < 8; off += 4) begin
      access("strobe word wr", mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_4,
             11'(base + off), {$urandom, $urandom});
    end
    access("strobe word rd", mem_stream_pkg::e_msg_rd, mem_stream_pkg::e_size_8, base, '0);
  endtask

  task automatic uncached_test;
    logic [10:0] base;
    base = 11'h2c0;
    access("uncached wr", mem_stream_pkg::e_msg_uc_wr, mem_stream_pkg::e_size_8, base,
           {$urandom, $urandom});
    access("uncached rd", mem_stream_pkg::e_msg_uc_rd, mem_stream_pkg::e_size_8, base, '0);
    access("uncached half wr", mem_stream_pkg::e_msg_uc_wr, mem_stream_pkg::e_size_2,
           11'(base + 6), {$urandom, $urandom});
    access("cached rd", mem_stream_pkg::e_msg_rd, mem_stream_pkg::e_size_8, base, '0);
    access("cached byte wr", mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_1,
           11'(base + 1), {$urandom, $urandom});
    access("uncached rd after mix", mem_stream_pkg::e_msg_uc_rd, mem_stream_pkg::e_size_8,
           base, '0);
  endtask

  task automatic backpressure_test;
    logic [hw-1:0] hdr_a, hdr_b, got_hdr;
    logic [dw-1:0] data_a, got_data;
    logic [10:0]   addr;
    addr   = 11'h3f8;
    data_a = {$urandom, $urandom};
    hdr_a  = make_header(mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_8, addr, next_tag);
    next_tag++;
    hdr_b  = make_header(mem_stream_pkg::e_msg_rd, mem_stream_pkg::e_size_8, addr, next_tag);
    next_tag++;
    @(negedge clk);
    rev_ready = 1'b0;
    push(hdr_a, data_a);
    push(hdr_b, '0);
    ref_write(mem_stream_pkg::e_size_8, addr, data_a);
    // second request stuck in the input slice
    repeat (20) begin
      @(negedge clk);
      check("backpressure fwd_ready", '0, dw'(fwd_ready));
    end
    check("backpressure rev_v", 64'd1, dw'(rev_v));
    pull(got_hdr, got_data);
    check("backpressure first header", dw'(hdr_a), dw'(got_hdr));
    check("backpressure first data", '0, got_data);
    pull(got_hdr, got_data);
    check("backpressure second header", dw'(hdr_b), dw'(got_hdr));
    check("backpressure second data", ref_word(addr), got_data);
  endtask

  task automatic random_test;
    logic [10:0] base, addr;
    mem_stream_pkg::msg_size_e s;
    int off;
    base = 11'h400;
    for (int w = 0; w < 8; w++) begin
      access("random init", mem_stream_pkg::e_msg_wr, mem_stream_pkg::e_size_8,
             11'(base + 8 * w), {$urandom, $urandom});
    end
    gaps = 1'b1;
    for (int i = 0; i < 40; i++) begin
      addr = 11'(base + 8 * $urandom_range(0, 7));
      if ($urandom_range(0, 1) == 1) begin
        s    = mem_stream_pkg::msg_size_e'($urandom_range(0, 3));
        off  = $urandom_range(0, 7) & ~((1 << s) - 1);  // aligned to size
        access("random wr", $urandom_range(0, 1) == 1 ? mem_stream_pkg::e_msg_uc_wr
               : mem_stream_pkg::e_msg_wr, s, 11'(addr + off), {$urandom, $urandom});
      end else begin
        access("random rd", $urandom_range(0, 1) == 1 ? mem_stream_pkg::e_msg_uc_rd
               : mem_stream_pkg::e_msg_rd, mem_stream_pkg::e_size_8, addr, '0);
      end
      repeat ($urandom_range(0, 2)) @(negedge clk);
    end
    gaps = 1'b0;
  endtask

  task automatic print_counts;
    $display("summary: %0d checks, %0d mismatches, %0d cycles", checks, mismatches, cycles);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("timeout: no result after %0d cycles, the DUT stopped responding", cycles);
      print_counts();
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(47));
    fwd_header = '0;
    fwd_data   = '0;
    fwd_v      = 1'b0;
    rev_ready  = 1'b0;
    next_tag   = '0;
    checks     = 0;
    mismatches = 0;
    gaps       = 1'b0;
    @(negedge clk);
    while (reset !== 1'b0) @(negedge clk);
    write_then_read_test();
    strobe_test();
    uncached_test();
    backpressure_test();
    random_test();
    print_counts();
    if (mismatches == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
logic/mem_stream_pkg.sv
logic/axi_bus_pkg.sv
logic/one_entry_buffer.sv
logic/axi_manager.sv
logic/axi_mem_subordinate.sv
logic/mem_axi_top.sv
bench/clock_gen.sv
bench/mem_axi_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= mem_axi_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status comes from the grep, so a missing pass line fails the target
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
